// ==== logic/fifo_macros.svh ====
// FIFO build constants
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// Number of storage slots
// Also the width of the one-hot pointer rings
// Must be at least 4 for the rotated overlap in the full flag
`define FIFO_DEPTH 8

// Width of one data word
`define FIFO_WIDTH 16

// Flops in each pointer and flag synchronizer
`define FIFO_SYNC_STAGES 2

`endif

// ==== logic/fifo_pkg.sv ====
// FIFO shared types
`include "fifo_macros.svh"

package fifo_pkg;

    // *************************************************************************
    // Pointer type
    // *************************************************************************

    // One bit per slot, exactly one bit set
    // Bit 0 marks slot 0, the reset position of both rings
    typedef logic [`FIFO_DEPTH-1:0] onehot_ptr_t;

    // *************************************************************************
    // Output register state
    // *************************************************************************

    // RD_EMPTY  -> output register holds no word
    // RD_LOADED -> output register holds a word, out_valid high
    typedef enum logic
    {
        RD_EMPTY  = 1'b0,
        RD_LOADED = 1'b1
    } rd_state_t;

endpackage

// ==== logic/fifo_synchronizer.sv ====
// Multi-flop synchronizer
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_synchronizer #(
    parameter int unsigned      WIDTH       = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [WIDTH-1:0] d_in,
    output logic [WIDTH-1:0] d_out
);

    // Chain length, shared by every crossing in the buffer
    localparam int unsigned STAGES = `FIFO_SYNC_STAGES;

    // Flop chain, index 0 samples the incoming value
    logic [WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            // Every stage starts at the agreed idle value
            for (int i = 0; i < STAGES; i++)
            begin
                sync_q[i] <= RESET_VALUE;
            end
        end
        else
        begin
            sync_q[0] <= d_in;
            // Shift toward the receiver
            for (int i = 1; i < STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Last stage is the only copy the receiver may use
    assign d_out = sync_q[STAGES-1];

endmodule

// ==== logic/fifo_full_detector.sv ====
// Conservative full flag
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_full_detector (
    input  logic                  clk,
    input  logic                  rstn,
    input  fifo_pkg::onehot_ptr_t read_pointer,
    input  fifo_pkg::onehot_ptr_t write_pointer,
    input  logic                  valid,
    output logic                  full
);

    import fifo_pkg::*;

    // Raw overlap, synchronized overlap, push/near-full history
    logic near_full;
    logic near_full_sync;
    logic push_seen;

    // Rotate a one-hot ring left by k slots
    function automatic onehot_ptr_t rotate_left(input onehot_ptr_t ptr, input int unsigned k);
        onehot_ptr_t rotated;
        rotated = (ptr << k) | (ptr >> (`FIFO_DEPTH - k));
        return rotated;
    endfunction

    // Three rotations need at least four slots
    if (`FIFO_DEPTH < 4)
    begin : g_depth_check
        $error("FIFO_DEPTH must be at least 4");
    end

    // *************************************************************************
    // Overlap of read pointer with write pointer + 1, + 2, + 3
    // *************************************************************************

    // Any hit means three or fewer free slots
    // Write == read is the empty case and gives no hit
    always_comb
    begin
        near_full = 1'b0;
        for (int unsigned k = 1; k <= 3; k++)
        begin
            near_full = near_full | (|(read_pointer & rotate_left(write_pointer, k)));
        end
    end

    // Carry the overlap into the write side, delayed like a real crossing
    fifo_synchronizer #(
        .WIDTH       (1),
        .RESET_VALUE (1'b0)
    ) u_full_sync (
        .clk   (clk),
        .rstn  (rstn),
        .d_in  (near_full),
        .d_out (near_full_sync)
    );

    // History flop
    // Set by a push or by an earlier near-full, so full only reports
    // after something actually moved the write side
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            push_seen <= 1'b0;
        else
            push_seen <= near_full_sync | valid;
    end

    assign full = near_full_sync & push_seen;

    // The delayed flag must stop pushes before the last free slot is taken
    a_no_push_into_last_slot: assert property (
        @(posedge clk) disable iff (!rstn)
        valid |-> !(|(read_pointer & rotate_left(write_pointer, 1)))
    );

endmodule

// ==== logic/fifo_empty_detector.sv ====
// Empty flag from synchronized write pointer
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_empty_detector (
    input  logic                  clk,
    input  logic                  rstn,
    input  fifo_pkg::onehot_ptr_t read_pointer,
    input  fifo_pkg::onehot_ptr_t write_pointer,
    output logic                  empty
);

    import fifo_pkg::*;

    // Write pointer as seen from the read side
    onehot_ptr_t write_pointer_sync;

    // *************************************************************************
    // Pointer crossing
    // *************************************************************************

    // Resets to slot 0, matching the write ring reset
    fifo_synchronizer #(
        .WIDTH       (`FIFO_DEPTH),
        .RESET_VALUE (onehot_ptr_t'(1))
    ) u_wr_ptr_sync (
        .clk   (clk),
        .rstn  (rstn),
        .d_in  (write_pointer),
        .d_out (write_pointer_sync)
    );

    // Same slot on both rings means nothing left to read
    // The synchronized copy lags, so empty may stay high a little long
    // but never falls early
    assign empty = |(read_pointer & write_pointer_sync);

endmodule

// ==== logic/fifo_write_port.sv ====
// FIFO input side
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_write_port (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   in_valid,
    input  logic [`FIFO_WIDTH-1:0] in_data,
    output logic                   in_ready,
    input  fifo_pkg::onehot_ptr_t  rd_ptr,
    output fifo_pkg::onehot_ptr_t  wr_ptr,
    output logic                   wr_en,
    output logic [`FIFO_WIDTH-1:0] wr_data
);

    // Conservative full flag from the detector
    logic full;

    // *************************************************************************
    // Handshake
    // *************************************************************************

    // Accept whenever full is low
    assign in_ready = ~full;

    // One push per accepted word, written straight into storage
    assign wr_en   = in_valid & in_ready;
    assign wr_data = in_data;

    // Write ring
    // Slot 0 after reset, rotate left once per push
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= {{(`FIFO_DEPTH-1){1'b0}}, 1'b1};
        end
        else if (wr_en)
        begin
            wr_ptr <= {wr_ptr[`FIFO_DEPTH-2:0], wr_ptr[`FIFO_DEPTH-1]};
        end
    end

    // Full detection against the read ring
    fifo_full_detector u_full_detector (
        .clk           (clk),
        .rstn          (rstn),
        .read_pointer  (rd_ptr),
        .write_pointer (wr_ptr),
        .valid         (wr_en),
        .full          (full)
    );

    // No push into a full buffer
    // After any push the rings must still differ, otherwise the word
    // just written landed on an unread slot
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |=> (wr_ptr != rd_ptr)
    );

endmodule

// ==== logic/fifo_storage.sv ====
// FIFO register array
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_storage (
    input  logic                   clk,
    input  logic                   wr_en,
    input  fifo_pkg::onehot_ptr_t  wr_ptr,
    input  logic [`FIFO_WIDTH-1:0] wr_data,
    input  fifo_pkg::onehot_ptr_t  rd_ptr,
    output logic [`FIFO_WIDTH-1:0] rd_data
);

    // One word per slot
    logic [`FIFO_WIDTH-1:0] mem [`FIFO_DEPTH];

    // *************************************************************************
    // Write
    // *************************************************************************

    // Only the slot with its pointer bit set takes the word
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `FIFO_DEPTH; i++)
        begin
            if (wr_en && wr_ptr[i])
                mem[i] <= wr_data;
        end
    end

    // *************************************************************************
    // Read
    // *************************************************************************

    // AND-OR mux, one-hot select needs no decoder
    always_comb
    begin
        rd_data = '0;
        for (int i = 0; i < `FIFO_DEPTH; i++)
        begin
            rd_data = rd_data | ({`FIFO_WIDTH{rd_ptr[i]}} & mem[i]);
        end
    end

endmodule

// ==== logic/fifo_read_port.sv ====
// FIFO output side
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_read_port (
    input  logic                   clk,
    input  logic                   rstn,
    input  fifo_pkg::onehot_ptr_t  wr_ptr,
    input  logic [`FIFO_WIDTH-1:0] rd_data,
    output fifo_pkg::onehot_ptr_t  rd_ptr,
    output logic                   out_valid,
    output logic [`FIFO_WIDTH-1:0] out_data,
    input  logic                   out_ready
);

    import fifo_pkg::*;

    // Output register FSM
    rd_state_t state_q;
    rd_state_t state_d;

    // Storage empty as seen from this side
    logic empty;
    // Output register takes a word this cycle, also the pop
    logic load;

    // Empty detection against the write ring
    fifo_empty_detector u_empty_detector (
        .clk           (clk),
        .rstn          (rstn),
        .read_pointer  (rd_ptr),
        .write_pointer (wr_ptr),
        .empty         (empty)
    );

    // *************************************************************************
    // Output register control
    // *************************************************************************

    // Load when a word waits and the register is free or draining now
    assign load = ~empty & ((state_q == RD_EMPTY) | out_ready);

    always_comb
    begin
        state_d = state_q;
        if (load)
            state_d = RD_LOADED;
        else if (out_ready)
            // Drained with nothing to replace it
            state_d = RD_EMPTY;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state_q <= RD_EMPTY;
        else
            state_q <= state_d;
    end

    assign out_valid = (state_q == RD_LOADED);

    // Payload register, only meaningful while loaded
    always_ff @(posedge clk)
    begin
        if (load)
            out_data <= rd_data;
    end

    // Read ring
    // Slot 0 after reset, rotate left once per pop
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            rd_ptr <= onehot_ptr_t'(1);
        else if (load)
            rd_ptr <= {rd_ptr[`FIFO_DEPTH-2:0], rd_ptr[`FIFO_DEPTH-1]};
    end

    // A pop never takes the slot the write side has not filled yet
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rstn)
        load |-> (rd_ptr != wr_ptr)
    );

endmodule

// ==== logic/fifo_top.sv ====
// One-hot pointer FIFO top
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_top (
    input  logic                   clk,
    input  logic                   rstn,
    // Input stream
    input  logic                   in_valid,
    input  logic [`FIFO_WIDTH-1:0] in_data,
    output logic                   in_ready,
    // Output stream
    output logic                   out_valid,
    output logic [`FIFO_WIDTH-1:0] out_data,
    input  logic                   out_ready,
    // Status
    output logic                   full
);

    import fifo_pkg::*;

    // *************************************************************************
    // Internal nets
    // *************************************************************************

    // Rings, each also crossing to the opposite side
    onehot_ptr_t            wr_ptr;
    onehot_ptr_t            rd_ptr;
    // Write path into storage
    logic                   wr_en;
    logic [`FIFO_WIDTH-1:0] wr_data;
    // Word at the read slot
    logic [`FIFO_WIDTH-1:0] rd_data;

    // Status is just the back-pressure seen at the input
    assign full = ~in_ready;

    fifo_write_port u_write_port (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .rd_ptr   (rd_ptr),
        .wr_ptr   (wr_ptr),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    fifo_storage u_storage (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_ptr  (wr_ptr),
        .wr_data (wr_data),
        .rd_ptr  (rd_ptr),
        .rd_data (rd_data)
    );

    fifo_read_port u_read_port (
        .clk       (clk),
        .rstn      (rstn),
        .wr_ptr    (wr_ptr),
        .rd_data   (rd_data),
        .rd_ptr    (rd_ptr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

// ==== bench/fifo_tb.sv ====
// FIFO testbench
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_tb;

    localparam int DEPTH         = `FIFO_DEPTH;
    localparam int ROWS          = 5;
    localparam int ROW_TIMEOUT   = 2000;
    localparam int DRAIN_TIMEOUT = 200;

    logic                   clk;
    logic                   rstn;
    logic                   in_valid;
    logic [`FIFO_WIDTH-1:0] in_data;
    logic                   in_ready;
    logic                   out_valid;
    logic [`FIFO_WIDTH-1:0] out_data;
    logic                   out_ready;
    logic                   full;

    // *************************************************************************
    // Phase table
    // *************************************************************************

    // Row 0 fills with the output stalled, the rest mix traffic
    int n_words       [ROWS] = '{12, 60, 60, 60, 30};
    int valid_pct     [ROWS] = '{100, 70, 95, 40, 80};
    int ready_pct     [ROWS] = '{0, 60, 30, 90, 50};
    // -1 means the flag is left open by random traffic
    int exp_full      [ROWS] = '{1, -1, -1, -1, -1};
    int exp_out_valid [ROWS] = '{1, -1, -1, -1, -1};

    // Scoreboard holds every accepted word not yet taken at the output
    logic [`FIFO_WIDTH-1:0] sb_q [$];
    int   seed = 32'h3b50471e;
    int   seq;
    int   offered;
    int   accepted;
    logic in_sent;
    logic prev_full;

    fifo_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .full      (full)
    );

    always #20 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else
            fail_stop($sformatf("Mismatch at %0t: %s expected %0h actual %0h",
                                $time, name, expected, actual));
    endtask

    // True with the given chance in percent
    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // *************************************************************************
    // One clock of traffic
    // *************************************************************************

    task automatic run_cycle(input int row, input int limit, input int vpct, input int rpct);
        @(negedge clk);
        // DUT outputs come from flops only, settled by now
        if (out_valid)
        begin
            assert (sb_q.size() > 0)
            else
                fail_stop("out_valid is high while no accepted word is outstanding");
            check_value("out_data", 32'(sb_q[0]), 32'(out_data));
        end
        assert (sb_q.size() <= DEPTH)
        else
            fail_stop("More words accepted than the buffer has slots");
        // Fill check, only meaningful with the output stalled
        if (rpct == 0 && full && !prev_full)
        begin
            assert (sb_q.size() >= DEPTH - 3)
            else
                fail_stop("full rose before DEPTH-3 words were accepted");
        end
        prev_full = full;
        // Word sent on the last edge leaves the bus
        if (in_sent)
            in_valid = 1'b0;
        in_sent = 1'b0;
        // Unsent word stays put with its data
        if (!in_valid && offered < limit && chance(vpct))
        begin
            in_valid = 1'b1;
            in_data  = {4'(row), 12'(seq)};
            seq++;
            offered++;
        end
        out_ready = chance(rpct);
        // Handshakes that complete on the coming rising edge
        if (in_valid && in_ready)
        begin
            sb_q.push_back(in_data);
            accepted++;
            in_sent = 1'b1;
        end
        if (out_valid && out_ready)
            void'(sb_q.pop_front());
    endtask

    // *************************************************************************
    // Main sequence
    // *************************************************************************

    initial
    begin
        int                  cycles;
        fifo_pkg::rd_state_t out_state;

        clk       = 1'b0;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        seq       = 0;
        offered   = 0;
        accepted  = 0;
        in_sent   = 1'b0;
        prev_full = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // Idle flags right after reset
        @(negedge clk);
        check_value("out_valid", 32'(0), 32'(out_valid));
        check_value("full", 32'(0), 32'(full));
        check_value("in_ready", 32'(1), 32'(in_ready));

        for (int r = 0; r < ROWS; r++)
        begin
            offered  = 0;
            accepted = 0;
            cycles   = 0;
            // Stalled rows end once full holds the input off
            while (accepted < n_words[r] && !(ready_pct[r] == 0 && full))
            begin
                run_cycle(r, n_words[r], valid_pct[r], ready_pct[r]);
                cycles++;
                if (cycles > ROW_TIMEOUT)
                    fail_stop($sformatf("Row %0d did not finish its words in time", r));
            end
            if (exp_full[r] >= 0)
                check_value("full", 32'(exp_full[r]), 32'(full));
            if (exp_out_valid[r] >= 0)
                check_value("out_valid", 32'(exp_out_valid[r]), 32'(out_valid));
            out_state = uut.u_read_port.state_q;
            $display("Row %0d done after %0d cycles, %0d words held, output register %s",
                     r, cycles, sb_q.size(), out_state.name());
        end

        // Drain everything with the output always ready
        cycles = 0;
        while (sb_q.size() > 0 || in_valid || out_valid)
        begin
            run_cycle(ROWS, 0, 0, 100);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                fail_stop("Buffer did not drain in time");
        end

        cycles = 0;
        while (full)
        begin
            run_cycle(ROWS, 0, 0, 100);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                fail_stop("full did not clear after draining");
        end

        // Nothing may appear once drained
        repeat (2 * DEPTH)
        begin
            run_cycle(ROWS, 0, 0, 100);
            check_value("out_valid", 32'(0), 32'(out_valid));
            check_value("full", 32'(0), 32'(full));
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_synchronizer.sv
logic/fifo_full_detector.sv
logic/fifo_empty_detector.sv
logic/fifo_write_port.sv
logic/fifo_storage.sv
logic/fifo_read_port.sv
logic/fifo_top.sv
bench/fifo_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --timing --assert --timescale 1ns/1ps
TOP        = fifo_tb
RTL_TOP    = fifo_top
FILELIST   = list.f
OBJ_DIR    = obj_dir
PASS_TEXT  = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
